//--- flist.f
src/lsu_pkg.sv
src/lsu_ctrl_fsm.sv
src/lsu_wdata_align.sv
src/lsu_response.sv
src/lsu_top.sv
tests/lsu_assertions.sv
tests/tb_lsu.sv

//--- Makefile
SIM   = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = tb_lsu
FLIST = flist.f
LOG   = sim.log
BIN   = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./$(BIN) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- tests/tb_lsu.sv
////////////////////////////////////////////////////////////////////////////
// load/store unit testbench
// table driven loads and stores against a word memory model with random
// grant and rvalid delays, error injection and per-row result checks
////////////////////////////////////////////////////////////////////////////

module tb_lsu;

  import lsu_pkg::*;

  localparam int NUM_ROWS  = 22;
  localparam int MEM_WORDS = 16;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * 20 + 20;  // rows plus reset

  typedef struct packed {
    logic       we;
    data_type_t dtype;
    addr_t      addr;
    word_t      wdata;
    byte_off_t  roff;    // register byte that goes to the addressed lane
    logic       sext;
    logic       err1;    // inject error on first part
    logic       err2;    // inject error on second part
    be_t        be1;
    be_t        be2;
    logic [1:0] nreq;    // bus requests expected
    word_t      m0;      // word at addr after the row
    word_t      m1;      // following word after the row
    word_t      rdata;
    logic       err;
    addr_t      last;    // addr_last_o after the row
  } row_t;

  logic     clk_i = 1'b0;
  logic     rst_ni;
  lsu_req_t drv_req;
  word_t    rdata, data_rdata;
  logic     data_valid, addr_incr_req, busy, load_err, store_err;
  addr_t    addr_last;
  mem_req_t mem_req, prev_req;
  logic     data_gnt, data_rvalid, data_err;

  row_t       rows [NUM_ROWS];
  word_t      mem [MEM_WORDS];
  logic [15:0] lfsr_q = 16'd30744;
  int         err_cnt = 0;
  int         nreq, gnt_wait, rv_cnt;
  be_t        seen_be [2];
  addr_t      seen_addr [2];  // bus address of each granted part
  logic       cur_err1, cur_err2, rv_err, stall_prev;
  word_t      rv_data;

  always #5 clk_i = ~clk_i;

  lsu_top i_lsu_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .core_req_i      (drv_req),
    .rdata_o         (rdata),
    .data_valid_o    (data_valid),
    .addr_incr_req_o (addr_incr_req),
    .busy_o          (busy),
    .addr_last_o     (addr_last),
    .load_err_o      (load_err),
    .store_err_o     (store_err),
    .mem_req_o       (mem_req),
    .data_gnt_i      (data_gnt),
    .data_rvalid_i   (data_rvalid),
    .data_err_i      (data_err),
    .data_rdata_i    (data_rdata)
  );

  bind lsu_top lsu_assertions i_lsu_assertions (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .state_i       (i_lsu_ctrl_fsm.state_q),
    .mem_req_i     (mem_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_err_i    (data_err_i)
  );

  // fibonacci lfsr x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output int v);
    v = 0;
    repeat (n) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = (v << 1) | int'(lfsr_q[0]);  // one step per bit
    end
  endtask

  task automatic report_mismatch(input string name, input word_t got, input word_t exp);
    $display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
    err_cnt++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus memory model
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int d;
    int idx;
    data_gnt = 1'b0;
    data_rvalid = 1'b0;
    data_err = 1'b0;
    data_rdata = '0;
    rv_cnt = 0;
    stall_prev = 1'b0;
    prev_req = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      for (int k = 0; k < 4; k++) mem[i][8*k +: 8] = 8'h80 + 8'(4 * i + k);  // 0x80 + byte addr
    end
    draw_bits(2, gnt_wait);
    forever begin
      @(negedge clk_i);
      if (stall_prev && (mem_req !== prev_req)) begin
        $display("bus request fields changed while waiting for grant at t=%0t", $time);
        err_cnt++;
      end
      stall_prev = mem_req.req && !data_gnt;
      prev_req   = mem_req;
      if (mem_req.req && data_gnt) begin
        idx = int'(mem_req.addr[5:2]);
        if (nreq < 2) begin
          seen_be[nreq]   = mem_req.be;
          seen_addr[nreq] = mem_req.addr;
        end
        rv_err = (nreq == 0) ? cur_err1 : cur_err2;
        nreq++;
        rv_data = mem[idx];
        if (mem_req.we && !rv_err) begin  // failed stores leave memory alone
          for (int k = 0; k < 4; k++) begin
            if (mem_req.be[k]) mem[idx][8*k +: 8] = mem_req.wdata[8*k +: 8];
          end
        end
        draw_bits(1, d);
        rv_cnt = d + 1;              // rvalid 1 or 2 cycles later
        draw_bits(2, gnt_wait);      // grant delay of the next request
      end else if (mem_req.req && gnt_wait > 0) begin
        gnt_wait--;
      end
      @(posedge clk_i);
      #1;
      data_rvalid = 1'b0;
      data_err    = 1'b0;
      if (rv_cnt > 0) begin
        rv_cnt--;
        if (rv_cnt == 0) begin
          data_rvalid = 1'b1;
          data_err    = rv_err;
          data_rdata  = rv_data;
        end
      end
      #1 data_gnt = mem_req.req && (gnt_wait == 0);  // grant follows the settled request
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_table();
    rows[0]  = '{1'b1, TYPE_WORD, 32'h10, 32'h11223344, 2'd0, 1'b0, 1'b0, 1'b0,
                 4'hF, 4'h0, 2'd1, 32'h11223344, 32'h97969594, 32'h0, 1'b0, 32'h10};
    rows[1]  = '{1'b0, TYPE_WORD, 32'h10, 32'h0, 2'd0, 1'b0, 1'b0, 1'b0,
                 4'hF, 4'h0, 2'd1, 32'h11223344, 32'h97969594, 32'h11223344, 1'b0, 32'h10};
    rows[2]  = '{1'b0, TYPE_BYTE, 32'h21, 32'h0, 2'd0, 1'b0, 1'b0, 1'b0,
                 4'h2, 4'h0, 2'd1, 32'hA3A2A1A0, 32'hA7A6A5A4, 32'h000000A1, 1'b0, 32'h21};
    rows[3]  = '{1'b0, TYPE_BYTE, 32'h23, 32'h0, 2'd0, 1'b1, 1'b0, 1'b0,
                 4'h8, 4'h0, 2'd1, 32'hA3A2A1A0, 32'hA7A6A5A4, 32'hFFFFFFA3, 1'b0, 32'h23};
    rows[4]  = '{1'b0, TYPE_BYTE, 32'h20, 32'h0, 2'd0, 1'b1, 1'b0, 1'b0,
                 4'h1, 4'h0, 2'd1, 32'hA3A2A1A0, 32'hA7A6A5A4, 32'hFFFFFFA0, 1'b0, 32'h20};
    rows[5]  = '{1'b0, TYPE_BYTE, 32'h12, 32'h0, 2'd0, 1'b1, 1'b0, 1'b0,
                 4'h4, 4'h0, 2'd1, 32'h11223344, 32'h97969594, 32'h00000022, 1'b0, 32'h12};
    rows[6]  = '{1'b0, TYPE_HALF, 32'h22, 32'h0, 2'd0, 1'b0, 1'b0, 1'b0,
                 4'hC, 4'h0, 2'd1, 32'hA3A2A1A0, 32'hA7A6A5A4, 32'h0000A3A2, 1'b0, 32'h22};
    rows[7]  = '{1'b0, TYPE_HALF, 32'h21, 32'h0, 2'd0, 1'b1, 1'b0, 1'b0,
                 4'h6, 4'h0, 2'd1, 32'hA3A2A1A0, 32'hA7A6A5A4, 32'hFFFFA2A1, 1'b0, 32'h21};
    rows[8]  = '{1'b0, TYPE_HALF, 32'h10, 32'h0, 2'd0, 1'b1, 1'b0, 1'b0,
                 4'h3, 4'h0, 2'd1, 32'h11223344, 32'h97969594, 32'h00003344, 1'b0, 32'h10};
    rows[9]  = '{1'b0, TYPE_HALF, 32'h23, 32'h0, 2'd0, 1'b1, 1'b0, 1'b0,
                 4'h8, 4'h1, 2'd2, 32'hA3A2A1A0, 32'hA7A6A5A4, 32'hFFFFA4A3, 1'b0, 32'h24};
    rows[10] = '{1'b0, TYPE_WORD, 32'h2A, 32'h0, 2'd0, 1'b0, 1'b0, 1'b0,
                 4'hC, 4'h3, 2'd2, 32'hABAAA9A8, 32'hAFAEADAC, 32'hADACABAA, 1'b0, 32'h2C};
    rows[11] = '{1'b1, TYPE_WORD, 32'h31, 32'hCAFEF00D, 2'd0, 1'b0, 1'b0, 1'b0,
                 4'hE, 4'h1, 2'd2, 32'hFEF00DB0, 32'hB7B6B5CA, 32'h0, 1'b0, 32'h34};
    rows[12] = '{1'b0, TYPE_WORD, 32'h31, 32'h0, 2'd0, 1'b0, 1'b0, 1'b0,
                 4'hE, 4'h1, 2'd2, 32'hFEF00DB0, 32'hB7B6B5CA, 32'hCAFEF00D, 1'b0, 32'h34};
    rows[13] = '{1'b1, TYPE_HALF, 32'h33, 32'h0000BEEF, 2'd0, 1'b0, 1'b0, 1'b0,
                 4'h8, 4'h1, 2'd2, 32'hEFF00DB0, 32'hB7B6B5BE, 32'h0, 1'b0, 32'h34};
    rows[14] = '{1'b1, TYPE_BYTE, 32'h3A, 32'h12345678, 2'd3, 1'b0, 1'b0, 1'b0,
                 4'h4, 4'h0, 2'd1, 32'hBB12B9B8, 32'hBFBEBDBC, 32'h0, 1'b0, 32'h3A};
    rows[15] = '{1'b1, TYPE_HALF, 32'h3C, 32'hAABB5566, 2'd2, 1'b0, 1'b0, 1'b0,
                 4'h3, 4'h0, 2'd1, 32'hBFBEAABB, 32'h83828180, 32'h0, 1'b0, 32'h3C};
    rows[16] = '{1'b0, TYPE_WORD, 32'h3C, 32'h0, 2'd0, 1'b0, 1'b0, 1'b0,
                 4'hF, 4'h0, 2'd1, 32'hBFBEAABB, 32'h83828180, 32'hBFBEAABB, 1'b0, 32'h3C};
    rows[17] = '{1'b0, TYPE_WORD, 32'h00, 32'h0, 2'd0, 1'b0, 1'b1, 1'b0,
                 4'hF, 4'h0, 2'd1, 32'h83828180, 32'h87868584, 32'h0, 1'b1, 32'h00};
    rows[18] = '{1'b1, TYPE_WORD, 32'h04, 32'h01020304, 2'd0, 1'b0, 1'b1, 1'b0,
                 4'hF, 4'h0, 2'd1, 32'h87868584, 32'h8B8A8988, 32'h0, 1'b1, 32'h04};
    rows[19] = '{1'b0, TYPE_WORD, 32'h05, 32'h0, 2'd0, 1'b0, 1'b1, 1'b0,
                 4'hE, 4'h0, 2'd1, 32'h87868584, 32'h8B8A8988, 32'h0, 1'b1, 32'h05};
    rows[20] = '{1'b1, TYPE_HALF, 32'h07, 32'h00001111, 2'd0, 1'b0, 1'b1, 1'b0,
                 4'h8, 4'h0, 2'd1, 32'h87868584, 32'h8B8A8988, 32'h0, 1'b1, 32'h07};
    rows[21] = '{1'b0, TYPE_WORD, 32'h0A, 32'h0, 2'd0, 1'b0, 1'b0, 1'b1,
                 4'hC, 4'h3, 2'd2, 32'h8B8A8988, 32'h8F8E8D8C, 32'h0, 1'b1, 32'h0C};
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one access from request to data_valid_o, then the row checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_row(input int r);
    row_t       row;
    logic       done, moved, incr_seen, got_lerr, got_serr;
    word_t      got_rdata;
    addr_t      word_addr;  // word holding the first byte
    logic [3:0] idx;
    int         errs_before;
    row = rows[r];
    done = 1'b0;
    moved = 1'b0;
    incr_seen = 1'b0;
    errs_before = err_cnt;
    @(posedge clk_i);
    #1;
    nreq = 0;
    cur_err1 = row.err1;
    cur_err2 = row.err2;
    drv_req = '{req: 1'b1, we: row.we, data_type: row.dtype, sign_ext: row.sext,
                reg_offset: row.roff, addr: row.addr, wdata: row.wdata};
    while (!done) begin
      @(negedge clk_i);
      if (!busy) report_mismatch("busy_o", 32'd0, 32'd1);
      if (addr_incr_req) incr_seen = 1'b1;
      if (data_valid) begin
        got_rdata = rdata;
        got_lerr  = load_err;
        got_serr  = store_err;
        done      = 1'b1;
      end else begin
        @(posedge clk_i);
        #1;
        if (addr_incr_req && !moved) begin  // core steps to the next word once
          drv_req.addr = {drv_req.addr[31:2], 2'b00} + 32'd4;
          moved = 1'b1;
        end
      end
    end
    @(posedge clk_i);
    #1 drv_req.req = 1'b0;
    idx = row.addr[5:2];
    word_addr = {row.addr[31:2], 2'b00};
    if (nreq != int'(row.nreq)) report_mismatch("request count", nreq, int'(row.nreq));
    if (seen_be[0] !== row.be1) report_mismatch("be first part", word_t'(seen_be[0]),
                                                word_t'(row.be1));
    if (seen_addr[0] !== word_addr) report_mismatch("addr first part", seen_addr[0], word_addr);
    if (row.nreq == 2'd2) begin
      if (seen_be[1] !== row.be2) report_mismatch("be second part", word_t'(seen_be[1]),
                                                  word_t'(row.be2));
      if (seen_addr[1] !== word_addr + 32'd4) begin
        report_mismatch("addr second part", seen_addr[1], word_addr + 32'd4);
      end
      if (!incr_seen) begin
        $display("addr_incr_req_o never went high during split access of row %0d", r);
        err_cnt++;
      end
    end
    if (mem[idx] !== row.m0) report_mismatch("memory word", mem[idx], row.m0);
    if (mem[idx + 4'd1] !== row.m1) report_mismatch("next memory word", mem[idx + 4'd1],
                                                    row.m1);
    if (got_lerr !== (row.err && !row.we)) report_mismatch("load_err_o", word_t'(got_lerr),
                                                           word_t'(row.err && !row.we));
    if (got_serr !== (row.err && row.we)) report_mismatch("store_err_o", word_t'(got_serr),
                                                          word_t'(row.err && row.we));
    if (!row.we && !row.err && (got_rdata !== row.rdata)) begin
      report_mismatch("rdata_o", got_rdata, row.rdata);
    end
    if (addr_last !== row.last) report_mismatch("addr_last_o", addr_last, row.last);
    $display("row %0d %s", r, (err_cnt == errs_before) ? "ok" : "failed");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_ni = 1'b0;
    drv_req = '0;
    nreq = 0;
    cur_err1 = 1'b0;
    cur_err2 = 1'b0;
    seen_be[0] = '0;
    seen_be[1] = '0;
    seen_addr[0] = '0;
    seen_addr[1] = '0;
    load_table();
    repeat (10) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    @(negedge clk_i);
    if ({mem_req.req, data_valid, addr_incr_req, busy, load_err, store_err} !== 6'b0) begin
      $display("control outputs not all low after reset");
      err_cnt++;
    end
    if (addr_last !== '0) report_mismatch("addr_last_o", addr_last, 32'd0);
    for (int r = 0; r < NUM_ROWS; r++) run_row(r);
    $display("rows run %0d, checks failed %0d", NUM_ROWS, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("watchdog expired after %0d cycles without finishing the table", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- tests/lsu_assertions.sv
////////////////////////////////////////////////////////////////////////////
// data bus protocol assertions for the load/store unit
// bound into lsu_top, sampled on the rising clock edge
////////////////////////////////////////////////////////////////////////////

module lsu_assertions (
  input logic               clk_i,
  input logic               rst_ni,
  input lsu_pkg::ls_state_e state_i,    // fsm state register
  input lsu_pkg::mem_req_t  mem_req_i,
  input logic               data_gnt_i,
  input logic               data_rvalid_i,
  input logic               data_err_i
);

  import lsu_pkg::*;

  // a grant while waiting for read data must come with that data
  gnt_in_wait_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (state_i == WAIT_RVALID) |-> !(data_gnt_i && !data_rvalid_i))
    else $error("grant in WAIT_RVALID without rvalid");

  rvalid_in_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (state_i == IDLE) |-> !data_rvalid_i)
    else $error("rvalid while the fsm is idle");

  err_with_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
      data_err_i |-> data_rvalid_i)  // error is a response attribute
    else $error("bus error without rvalid");

  req_addr_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
      mem_req_i.req |-> !$isunknown(mem_req_i.addr))
    else $error("bus request with unknown address");

endmodule

//--- src/lsu_top.sv
////////////////////////////////////////////////////////////////////////////
// load/store unit top level
// connects the transaction fsm, store alignment and load response to the
// core request and the request/grant/rvalid data bus
////////////////////////////////////////////////////////////////////////////

module lsu_top (
  input  logic              clk_i,
  input  logic              rst_ni,

  // execute stage side
  input  lsu_pkg::lsu_req_t core_req_i,
  output lsu_pkg::word_t    rdata_o,
  output logic              data_valid_o,
  output logic              addr_incr_req_o,
  output logic              busy_o,
  output lsu_pkg::addr_t    addr_last_o,     // for trap value
  output logic              load_err_o,
  output logic              store_err_o,

  // data bus side
  output lsu_pkg::mem_req_t mem_req_o,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  input  logic              data_err_i,
  input  lsu_pkg::word_t    data_rdata_i
);

  import lsu_pkg::*;

  logic     req;           // bus request from fsm
  logic     second_part;
  logic     rsp_err;
  be_t      be;
  word_t    wdata;
  lsu_req_t req_lane;      // core request with the lane offset of the access

  // in the second part the core address is the next word, lane offset is 0,
  // so the offset of the first part comes from the last granted address
  always_comb begin
    req_lane = core_req_i;
    if (second_part) begin
      req_lane.addr[OFF_W-1:0] = addr_last_o[OFF_W-1:0];
    end
  end

  lsu_ctrl_fsm i_lsu_ctrl_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .core_req_i      (core_req_i),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .data_err_i      (data_err_i),
    .mem_req_o       (req),
    .second_part_o   (second_part),
    .rsp_err_o       (rsp_err),
    .data_valid_o    (data_valid_o),
    .addr_incr_req_o (addr_incr_req_o),
    .busy_o          (busy_o),
    .addr_last_o     (addr_last_o)
  );

  lsu_wdata_align i_lsu_wdata_align (
    .core_req_i    (req_lane),
    .second_part_i (second_part),
    .mem_be_o      (be),
    .mem_wdata_o   (wdata)
  );

  lsu_response i_lsu_response (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .core_req_i    (req_lane),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .second_part_i (second_part),
    .rsp_err_i     (rsp_err),
    .rdata_o       (rdata_o),
    .load_err_o    (load_err_o),
    .store_err_o   (store_err_o)
  );

  // bus address is always word aligned
  assign mem_req_o = '{
    req:   req,
    we:    core_req_i.we,
    be:    be,
    addr:  {core_req_i.addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}},
    wdata: wdata
  };

endmodule

//--- src/lsu_response.sv
////////////////////////////////////////////////////////////////////////////
// load response path
// takes the access attributes at grant, keeps the first word of a split
// load, realigns and extends read data and sorts bus errors
////////////////////////////////////////////////////////////////////////////

module lsu_response (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  lsu_pkg::lsu_req_t core_req_i,

  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  input  lsu_pkg::word_t    data_rdata_i,

  input  logic              second_part_i,  // split access in progress
  input  logic              rsp_err_i,      // error with rvalid

  output lsu_pkg::word_t    rdata_o,        // realigned, extended load data
  output logic              load_err_o,
  output logic              store_err_o
);

  import lsu_pkg::*;

  rsp_ctrl_t ctrl_q, ctrl_d;
  word_t     rdata_q;      // first word of a split load
  word_t     word_data;    // assembled word
  logic [15:0] half_data;  // selected halfword before extension
  logic [7:0]  byte_data;  // selected byte before extension
  logic [4:0]  lane_lsb;   // bit index of the addressed lane

  ////////////////////////////////////////////////////////////////////////////
  // attribute and data capture
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl_d = ctrl_q;
    if (data_gnt_i) begin
      ctrl_d.offset    = core_req_i.addr[OFF_W-1:0];
      ctrl_d.data_type = core_req_i.data_type;
      ctrl_d.sign_ext  = core_req_i.sign_ext;
      ctrl_d.we        = core_req_i.we;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q <= ctrl_d;
    end
  end

  // read word of the first part, the low bytes of a split load
  always_ff @(posedge clk_i) begin
    if (data_rvalid_i && !ctrl_q.we && second_part_i) begin
      rdata_q <= data_rdata_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // realignment and extension
  ////////////////////////////////////////////////////////////////////////////

  assign lane_lsb = {ctrl_q.offset, 3'b000};

  // split word: upper lanes of the held word, then low lanes of the new one
  always_comb begin
    unique case (ctrl_q.offset)
      2'b00:   word_data = data_rdata_i;
      2'b01:   word_data = {data_rdata_i[7:0], rdata_q[31:8]};
      2'b10:   word_data = {data_rdata_i[15:0], rdata_q[31:16]};
      default: word_data = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  // halfword at offset 3 straddles the two words
  assign half_data = (ctrl_q.offset == 2'b11) ? {data_rdata_i[7:0], rdata_q[31:24]}
                                              : data_rdata_i[lane_lsb +: 16];
  assign byte_data = data_rdata_i[lane_lsb +: 8];

  always_comb begin
    unique case (ctrl_q.data_type)
      TYPE_WORD: rdata_o = word_data;
      TYPE_HALF: rdata_o = {{16{ctrl_q.sign_ext & half_data[15]}}, half_data};
      TYPE_BYTE, 2'b11: rdata_o = {{24{ctrl_q.sign_ext & byte_data[7]}}, byte_data};
    endcase
  end

  // error type follows the access that owns this rvalid
  assign load_err_o  = rsp_err_i & ~ctrl_q.we;
  assign store_err_o = rsp_err_i &  ctrl_q.we;

endmodule

//--- src/lsu_wdata_align.sv
////////////////////////////////////////////////////////////////////////////
// store data alignment
// byte enables for either part of an access and rotation of the store
// word into its byte lanes
////////////////////////////////////////////////////////////////////////////

module lsu_wdata_align (
  input  lsu_pkg::lsu_req_t core_req_i,
  input  logic              second_part_i,  // second word of a split access
  output lsu_pkg::be_t      mem_be_o,
  output lsu_pkg::word_t    mem_wdata_o
);

  import lsu_pkg::*;

  byte_off_t offset;
  byte_off_t rot;          // left rotation in bytes
  logic [2*DATA_W-1:0] wide;  // doubled word, rotated by a shift

  assign offset = core_req_i.addr[OFF_W-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (core_req_i.data_type)
      TYPE_WORD: begin
        if (!second_part_i) begin
          mem_be_o = 4'b1111 << offset;              // offset .. lane 3
        end else begin
          mem_be_o = (4'b0001 << offset) - 4'b0001;  // lane 0 .. offset-1
        end
      end

      TYPE_HALF: begin
        if (!second_part_i) begin
          unique case (offset)
            2'b00:   mem_be_o = 4'b0011;
            2'b01:   mem_be_o = 4'b0110;
            2'b10:   mem_be_o = 4'b1100;
            default: mem_be_o = 4'b1000;  // upper byte spills to next word
          endcase
        end else begin
          mem_be_o = 4'b0001;  // spilled upper byte
        end
      end

      // code 3 acts as a byte
      TYPE_BYTE, 2'b11: mem_be_o = 4'b0001 << offset;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // lane rotation
  ////////////////////////////////////////////////////////////////////////////

  // register byte reg_offset lands in lane offset, wraps mod 4
  assign rot = offset - core_req_i.reg_offset;

  // same rotation serves both parts of a split store
  assign wide        = {core_req_i.wdata, core_req_i.wdata} << {rot, 3'b000};
  assign mem_wdata_o = wide[2*DATA_W-1:DATA_W];  // upper half is the rotated word

endmodule

//--- src/lsu_ctrl_fsm.sv
////////////////////////////////////////////////////////////////////////////
// load/store transaction fsm
// issues one or two bus requests per access, tracks the second part of a
// split access, keeps the last granted address and the busy flag
////////////////////////////////////////////////////////////////////////////

module lsu_ctrl_fsm (
  input  logic             clk_i,
  input  logic             rst_ni,

  input  lsu_pkg::lsu_req_t core_req_i,      // request from execute stage

  input  logic             data_gnt_i,
  input  logic             data_rvalid_i,
  input  logic             data_err_i,
  output logic             mem_req_o,       // bus request strobe

  output logic             second_part_o,   // split access past its first grant
  output logic             rsp_err_o,       // bus error qualified by rvalid

  output logic             data_valid_o,    // access complete
  output logic             addr_incr_req_o, // core moves addr to the next word
  output logic             busy_o,
  output lsu_pkg::addr_t   addr_last_o
);

  import lsu_pkg::*;

  ls_state_e state_q, state_d;
  logic      second_part_q, second_part_d;
  addr_t     addr_last_q, addr_last_d;
  logic      split_access;

  // a word needs two accesses at any offset but 0, a halfword only at offset 3
  assign split_access =
      ((core_req_i.data_type == TYPE_WORD) && (core_req_i.addr[OFF_W-1:0] != '0)) ||
      ((core_req_i.data_type == TYPE_HALF) && (core_req_i.addr[OFF_W-1:0] == 2'b11));

  assign rsp_err_o = data_rvalid_i & data_err_i;

  ////////////////////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    second_part_d   = second_part_q;
    mem_req_o       = 1'b0;
    data_valid_o    = 1'b0;
    addr_incr_req_o = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (core_req_i.req) begin
          mem_req_o = 1'b1;  // no register between core and bus
          if (data_gnt_i) begin
            second_part_d = split_access;
            state_d       = split_access ? WAIT_RVALID_MIS : WAIT_RVALID;
          end else begin
            state_d       = split_access ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      WAIT_GNT_MIS: begin
        mem_req_o = 1'b1;  // hold until granted
        if (data_gnt_i) begin
          second_part_d = 1'b1;
          state_d       = WAIT_RVALID_MIS;
        end
      end

      WAIT_RVALID_MIS: begin
        addr_incr_req_o = 1'b1;  // core points at the next word meanwhile
        if (data_rvalid_i) begin
          if (data_err_i) begin
            // first part failed, drop the second one
            data_valid_o  = 1'b1;
            second_part_d = 1'b0;
            state_d       = IDLE;
          end else begin
            mem_req_o = 1'b1;  // second request goes out with the first rvalid
            state_d   = data_gnt_i ? WAIT_RVALID : WAIT_GNT;
          end
        end
      end

      WAIT_GNT: begin
        addr_incr_req_o = second_part_q;  // keep the next-word address while stalled
        mem_req_o       = 1'b1;
        if (data_gnt_i) begin
          state_d = WAIT_RVALID;
        end
      end

      WAIT_RVALID: begin
        if (data_rvalid_i) begin
          data_valid_o  = 1'b1;  // error or not, the access is over
          second_part_d = 1'b0;
          state_d       = IDLE;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  // byte address of the last granted part, frozen on a bus error for trap value
  always_comb begin
    addr_last_d = addr_last_q;
    if (mem_req_o && data_gnt_i && !rsp_err_o) begin
      addr_last_d = core_req_i.addr;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= IDLE;
      second_part_q <= 1'b0;
      addr_last_q   <= '0;
    end else begin
      state_q       <= state_d;
      second_part_q <= second_part_d;
      addr_last_q   <= addr_last_d;
    end
  end

  assign second_part_o = second_part_q;
  assign addr_last_o   = addr_last_q;

  // busy while a request is up or a read response is still owed
  assign busy_o = mem_req_o | (state_q == WAIT_RVALID) | (state_q == WAIT_RVALID_MIS);

endmodule

//--- src/lsu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// load/store unit shared definitions
// widths, vector types, access size codes, fsm states and the packed
// request, bus and response-control structs
////////////////////////////////////////////////////////////////////////////

package lsu_pkg;

  // widths fixed by the 32-bit data bus
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;  // one enable per byte lane
  localparam int unsigned OFF_W  = 2;           // byte offset inside a word

  typedef logic [ADDR_W-1:0] addr_t;      // byte address
  typedef logic [DATA_W-1:0] word_t;      // data word
  typedef logic [BE_W-1:0]   be_t;        // byte-enable mask
  typedef logic [OFF_W-1:0]  byte_off_t;  // lane index
  typedef logic [1:0]        data_type_t; // access size

  // access size codes, code 3 behaves as a byte
  localparam data_type_t TYPE_WORD = 2'd0;
  localparam data_type_t TYPE_HALF = 2'd1;
  localparam data_type_t TYPE_BYTE = 2'd2;

  // transaction states, the _MIS states belong to the first part of a split
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT_MIS,
    WAIT_RVALID_MIS,
    WAIT_GNT,
    WAIT_RVALID
  } ls_state_e;

  // request from the execute stage
  typedef struct packed {
    logic       req;        // request strobe
    logic       we;         // store when set
    data_type_t data_type;
    logic       sign_ext;   // sign-extend loaded halfwords and bytes
    byte_off_t  reg_offset; // register byte that goes to the addressed lane
    addr_t      addr;       // full byte address from the adder
    word_t      wdata;      // store data, not yet rotated
  } lsu_req_t;

  // request side of the data bus
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;   // always word aligned
    word_t wdata;  // already in its byte lanes
  } mem_req_t;

  // attributes of the outstanding transaction, taken at grant
  typedef struct packed {
    byte_off_t  offset;
    data_type_t data_type;
    logic       sign_ext;
    logic       we;
  } rsp_ctrl_t;

endpackage
